/* design/hisPkg.sv */
package hisPkg;

    // histogram geometry
    localparam int PIXEL_NUM = 4;
    localparam int BIN_NUM = 16;
    // samples per pixel within one acquisition
    localparam int SAMPLES_PER_PIXEL = 4;
    // acquisitions per frame out of reset
    localparam int DEFAULT_ACQ = 1;
    // one row of BIN_NUM counters per pixel
    localparam int RAM_DEPTH = PIXEL_NUM * BIN_NUM;

    // quantized arrival time
    typedef logic [$clog2(BIN_NUM)-1:0] binT;
    typedef logic [$clog2(PIXEL_NUM)-1:0] pixelT;
    // 15 acq x 4 samples tops out at 60, no saturation
    typedef logic [7:0] countT;
    // legal range 1..15
    typedef logic [3:0] acqT;
    // wraps
    typedef logic [7:0] frameCntT;
    // {pixel, bin}
    typedef logic [$clog2(RAM_DEPTH)-1:0] ramAddrT;

    // sequencer phases
    typedef enum logic [1:0] {
        CLEAR,
        COLLECT,
        DRAIN,
        REPORT
    } seqStateT;

endpackage

/* design/frameConfig.sv */
module frameConfig (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             cfgWrite,
    input  hisPkg::acqT      cfgAcq,
    input  logic             frameStart,
    input  logic             frameDone,
    output hisPkg::acqT      acqPerFrame,
    output hisPkg::frameCntT frameCount
);
    import hisPkg::*;

    // value written by software, waits for the next frame
    acqT pendingAcq;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            pendingAcq  <= acqT'(DEFAULT_ACQ);
            acqPerFrame <= acqT'(DEFAULT_ACQ);
        end else begin
            // zero acquisitions makes no sense, drop it
            if (cfgWrite && (cfgAcq != '0)) begin
                pendingAcq <= cfgAcq;
            end
            // shadow copy, frame length fixed once collection starts
            if (frameStart) begin
                acqPerFrame <= pendingAcq;
            end
        end
    end

    // completed frames, free running
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            frameCount <= '0;
        end else if (frameDone) begin
            frameCount <= frameCount + 1'b1;
        end
    end

endmodule

/* design/histSeqCtrl.sv */
module histSeqCtrl (
    input  logic            clk,
    input  logic            combin_res,
    input  logic            sampleReq,
    input  hisPkg::binT     sampleBin,
    output logic            sampleAck,
    input  hisPkg::acqT     acqPerFrame,
    output logic            incValid,
    output hisPkg::ramAddrT incAddr,
    output logic            clrValid,
    output hisPkg::ramAddrT clrAddr,
    output logic            clrPeaks,
    output logic            reportStart,
    input  logic            reportDone,
    output logic            frameStart,
    output logic            frameDone
);
    import hisPkg::*;

    seqStateT state;
    // nested counters, sample inside pixel inside acquisition
    logic [$clog2(SAMPLES_PER_PIXEL)-1:0] sampleCnt;
    pixelT pixelCnt;
    acqT   acqCnt;
    // two-cycle wait for the pipeline to settle
    logic  drainCnt;
    // new request seen while collecting
    logic  accept;

    assign accept = (state == COLLECT) && sampleReq && !sampleAck;

    // sweep runs for the whole CLEAR phase
    assign clrValid   = (state == CLEAR);
    assign clrPeaks   = (state == CLEAR);
    // last sweep address, frame length gets latched here
    assign frameStart = (state == CLEAR) && (clrAddr == ramAddrT'(RAM_DEPTH - 1));

    // sample handshake and increment issue
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleAck <= 1'b0;
            incValid  <= 1'b0;
            incAddr   <= '0;
        end else begin
            incValid <= accept;
            if (accept) begin
                sampleAck <= 1'b1;
                // row select by pixel, column by bin
                incAddr   <= {pixelCnt, sampleBin};
            end else if (sampleAck && !sampleReq) begin
                // source let go, close the four-phase cycle
                sampleAck <= 1'b0;
            end
        end
    end

    // state machine and counters
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state       <= CLEAR;
            clrAddr     <= '0;
            sampleCnt   <= '0;
            pixelCnt    <= '0;
            acqCnt      <= '0;
            drainCnt    <= 1'b0;
            reportStart <= 1'b0;
            frameDone   <= 1'b0;
        end else begin
            reportStart <= 1'b0;
            frameDone   <= 1'b0;
            case (state)
                CLEAR: begin
                    // wraps back to zero for the next sweep
                    clrAddr <= clrAddr + 1'b1;
                    if (frameStart) begin
                        state <= COLLECT;
                    end
                end
                COLLECT: begin
                    if (accept) begin
                        if (sampleCnt == $bits(sampleCnt)'(SAMPLES_PER_PIXEL - 1)) begin
                            sampleCnt <= '0;
                            if (pixelCnt == pixelT'(PIXEL_NUM - 1)) begin
                                pixelCnt <= '0;
                                if (acqCnt == acqPerFrame - acqT'(1)) begin
                                    // last sample of the frame
                                    acqCnt <= '0;
                                    state  <= DRAIN;
                                end else begin
                                    acqCnt <= acqCnt + 1'b1;
                                end
                            end else begin
                                pixelCnt <= pixelCnt + 1'b1;
                            end
                        end else begin
                            sampleCnt <= sampleCnt + 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    // also hold off while the last ack is still up
                    if (!drainCnt) begin
                        drainCnt <= 1'b1;
                    end else if (!sampleAck) begin
                        drainCnt    <= 1'b0;
                        reportStart <= 1'b1;
                        state       <= REPORT;
                    end
                end
                REPORT: begin
                    if (reportDone) begin
                        frameDone <= 1'b1;
                        state     <= CLEAR;
                    end
                end
                default: state <= CLEAR;
            endcase
        end
    end

endmodule

/* design/histRam.sv */
module histRam (
    input  logic            clk,
    input  logic            incValid,
    input  hisPkg::ramAddrT incAddr,
    input  logic            clrValid,
    input  hisPkg::ramAddrT clrAddr,
    output logic            newValid,
    output hisPkg::pixelT   newPixel,
    output hisPkg::binT     newBin,
    output hisPkg::countT   newCount
);
    import hisPkg::*;

    countT mem [RAM_DEPTH];
    // count seen by the current increment
    countT baseCount;
    // previous result not yet in the array
    logic  fwdHit;

    // output regs double as the write-back stage
    assign fwdHit    = newValid && ({newPixel, newBin} == incAddr);
    assign baseCount = fwdHit ? newCount : mem[incAddr];

    // increment result, one cycle after issue
    always_ff @(posedge clk) begin
        newValid <= incValid;
        if (incValid) begin
            {newPixel, newBin} <= incAddr;
            newCount           <= baseCount + 1'b1;
        end
    end

    // single write port, sweep has priority
    always_ff @(posedge clk) begin
        if (clrValid) begin
            mem[clrAddr] <= '0;
        end else if (newValid) begin
            mem[{newPixel, newBin}] <= newCount;
        end
    end

endmodule

/* design/peakTracker.sv */
module peakTracker (
    input  logic          clk,
    input  logic          combin_res,
    input  logic          newValid,
    input  hisPkg::pixelT newPixel,
    input  hisPkg::binT   newBin,
    input  hisPkg::countT newCount,
    input  logic          clrPeaks,
    input  logic          reportStart,
    output logic          reportDone,
    output logic          peakReq,
    input  logic          peakAck,
    output hisPkg::pixelT peakPixel,
    output hisPkg::binT   peakBin,
    output hisPkg::countT peakCount
);
    import hisPkg::*;

    // running maximum and its bin, per pixel
    countT maxCount [PIXEL_NUM];
    binT   maxBin   [PIXEL_NUM];

    // report walk
    logic  rptActive;
    pixelT rptPixel;
    pixelT nextPixel;
    // present a new record this cycle
    logic  loadRec;

    assign nextPixel = reportStart ? pixelT'(0) : pixelT'(rptPixel + 1'b1);
    // previous record fully retired and more pixels left
    assign loadRec = reportStart ||
        (rptActive && !peakReq && !peakAck && (rptPixel != pixelT'(PIXEL_NUM - 1)));

    // strictly greater only, earliest bin wins a tie
    always_ff @(posedge clk) begin
        if (clrPeaks) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                maxCount[p] <= '0;
                maxBin[p]   <= '0;
            end
        end else if (newValid && (newCount > maxCount[newPixel])) begin
            maxCount[newPixel] <= newCount;
            maxBin[newPixel]   <= newBin;
        end
    end

    // four-phase output handshake
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            rptActive  <= 1'b0;
            rptPixel   <= '0;
            peakReq    <= 1'b0;
            reportDone <= 1'b0;
        end else begin
            reportDone <= 1'b0;
            if (loadRec) begin
                rptActive <= 1'b1;
                rptPixel  <= nextPixel;
                peakReq   <= 1'b1;
            end else if (peakReq && peakAck) begin
                peakReq <= 1'b0;
            end else if (rptActive && !peakReq && !peakAck) begin
                // last pixel acknowledged and released
                rptActive  <= 1'b0;
                reportDone <= 1'b1;
            end
        end
    end

    // record held until the next load
    always_ff @(posedge clk) begin
        if (loadRec) begin
            peakPixel <= nextPixel;
            peakBin   <= maxBin[nextPixel];
            peakCount <= maxCount[nextPixel];
        end
    end

endmodule

/* design/hisBuilder.sv */
module hisBuilder (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             sampleReq,
    input  hisPkg::binT      sampleBin,
    output logic             sampleAck,
    output logic             peakReq,
    input  logic             peakAck,
    output hisPkg::pixelT    peakPixel,
    output hisPkg::binT      peakBin,
    output hisPkg::countT    peakCount,
    input  logic             cfgWrite,
    input  hisPkg::acqT      cfgAcq,
    output hisPkg::frameCntT frameCount
);
    import hisPkg::*;

    // config to sequencer
    acqT     acqPerFrame;
    logic    frameStart;
    logic    frameDone;
    // sequencer to memory
    logic    incValid;
    ramAddrT incAddr;
    logic    clrValid;
    ramAddrT clrAddr;
    // memory to tracker
    logic    newValid;
    pixelT   newPixel;
    binT     newBin;
    countT   newCount;
    // sequencer and tracker
    logic    clrPeaks;
    logic    reportStart;
    logic    reportDone;

    frameConfig uFrameConfig (
        .clk, .combin_res, .cfgWrite, .cfgAcq,
        .frameStart, .frameDone, .acqPerFrame, .frameCount
    );

    histSeqCtrl uHistSeqCtrl (
        .clk, .combin_res, .sampleReq, .sampleBin, .sampleAck, .acqPerFrame,
        .incValid, .incAddr, .clrValid, .clrAddr, .clrPeaks,
        .reportStart, .reportDone, .frameStart, .frameDone
    );

    histRam uHistRam (
        .clk, .incValid, .incAddr, .clrValid, .clrAddr,
        .newValid, .newPixel, .newBin, .newCount
    );

    peakTracker uPeakTracker (
        .clk, .combin_res, .newValid, .newPixel, .newBin, .newCount,
        .clrPeaks, .reportStart, .reportDone,
        .peakReq, .peakAck, .peakPixel, .peakBin, .peakCount
    );

endmodule

/* testbench/hisBuilder_chk.sv */
module hisBuilder_chk (
    input logic          clk,
    input logic          combin_res,
    input logic          sampleReq,
    input logic          sampleAck,
    input logic          peakReq,
    input logic          peakAck,
    input hisPkg::pixelT peakPixel,
    input hisPkg::binT   peakBin,
    input hisPkg::countT peakCount
);

    // ack only answers a live request
    ackNeedsReq: assert property (@(posedge clk) disable iff (!combin_res)
        $rose(sampleAck) |-> sampleReq)
        else $error("sampleAck rose without sampleReq");

    // record frozen until the sink answers
    peakHeld: assert property (@(posedge clk) disable iff (!combin_res)
        (peakReq && !peakAck) |=> $stable({peakPixel, peakBin, peakCount}))
        else $error("peak record changed before peakAck");

    // collection and report never overlap
    noOverlap: assert property (@(posedge clk) disable iff (!combin_res)
        !(peakReq && sampleAck))
        else $error("peakReq and sampleAck high together");

endmodule

/* testbench/hisBuilderTb.sv */
module hisBuilderTb;
    import hisPkg::*;

    logic     clk;
    logic     combin_res;
    logic     sampleReq;
    binT      sampleBin;
    logic     sampleAck;
    logic     peakReq;
    logic     peakAck;
    pixelT    peakPixel;
    binT      peakBin;
    countT    peakCount;
    logic     cfgWrite;
    acqT      cfgAcq;
    frameCntT frameCount;

    // parsed vectors, one entry per test
    int          testAcq[$];
    int          testCfgIdx[$];
    int          testCfgVal[$];
    // one word per acquisition, 16 bins pixel-major
    logic [63:0] acqWords[$];
    // PIXEL_NUM entries per test
    binT         expBin[$];
    countT       expCount[$];

    int          errors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    // sample acks, cumulative over the run
    int          ackTotal = 0;
    int          ackAtReport = 0;
    logic        ackPrev = 1'b0;
    logic        reqPrev = 1'b0;
    logic [31:0] rngState = 32'd73;

    hisBuilder u_hisBuilder (.*);

    bind hisBuilder hisBuilder_chk uHisBuilderChk (
        .clk, .combin_res, .sampleReq, .sampleAck,
        .peakReq, .peakAck, .peakPixel, .peakBin, .peakCount
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ack counting, snapshot at each peak request
    always @(posedge clk) begin
        if (sampleAck && !ackPrev) begin
            ackTotal++;
        end
        if (peakReq && !reqPrev) begin
            ackAtReport = ackTotal;
        end
        if (sampleAck && peakReq) begin
            errors++;
            $display("[ERROR] %0t sampleAck high during the peak report", $time);
        end
        ackPrev = sampleAck;
        reqPrev = peakReq;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic checkBin(input binT got, input binT exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkCount(input countT got, input countT exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkPixel(input pixelT got, input pixelT exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkFrame(input frameCntT got, input frameCntT exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic bit loadVectors();
        int          fd;
        int          code;
        int          tn;
        int          acq;
        int          ci;
        int          cv;
        int          eb [4];
        int          ec [4];
        string       line;
        byte         lead;
        logic [63:0] word;
        fd = $fopen("testbench/hisBuilder_vectors.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0) begin
                lead = line.getc(0);
                if (lead == "T") begin
                    code = $sscanf(line, "T %d %d %d %d", tn, acq, ci, cv);
                    testAcq.push_back(acq);
                    testCfgIdx.push_back(ci);
                    testCfgVal.push_back(cv);
                end else if (lead == "S") begin
                    code = $sscanf(line, "S %h", word);
                    acqWords.push_back(word);
                end else if (lead == "E") begin
                    code = $sscanf(line, "E %h %h %h %h %h %h %h %h",
                        eb[0], ec[0], eb[1], ec[1], eb[2], ec[2], eb[3], ec[3]);
                    for (int p = 0; p < PIXEL_NUM; p++) begin
                        expBin.push_back(binT'(eb[p]));
                        expCount.push_back(countT'(ec[p]));
                    end
                end
            end
        end
        $fclose(fd);
        return testAcq.size() > 0;
    endfunction

    task automatic writeConfig(input acqT value);
        @(posedge clk);
        cfgWrite <= 1'b1;
        cfgAcq   <= value;
        @(posedge clk);
        cfgWrite <= 1'b0;
    endtask

    // one four-phase sample transfer, bails out if a report starts
    task automatic sendSample(input binT value);
        @(posedge clk);
        sampleReq <= 1'b1;
        sampleBin <= value;
        @(posedge clk);
        while (!sampleAck && !peakReq) @(posedge clk);
        sampleReq <= 1'b0;
        @(posedge clk);
        while (sampleAck) @(posedge clk);
    endtask

    task automatic receiveReport(input int t);
        pixelT heldPixel;
        binT   heldBin;
        countT heldCount;
        int    delay;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            @(posedge clk);
            while (!peakReq) @(posedge clk);
            heldPixel = peakPixel;
            heldBin   = peakBin;
            heldCount = peakCount;
            rngState  = xorshift(rngState);
            delay     = int'(rngState % 4);
            // sink stalls, record must hold
            repeat (delay) begin
                @(posedge clk);
                checkPixel(peakPixel, heldPixel, "held pixel");
                checkBin(peakBin, heldBin, "held bin");
                checkCount(peakCount, heldCount, "held count");
            end
            peakAck <= 1'b1;
            @(posedge clk);
            while (peakReq) @(posedge clk);
            peakAck <= 1'b0;
            checkPixel(heldPixel, pixelT'(p), "peak pixel");
            checkBin(heldBin, expBin[t * PIXEL_NUM + p], "peak bin");
            checkCount(heldCount, expCount[t * PIXEL_NUM + p], "peak count");
        end
    endtask

    task automatic watchdog(input int limit);
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic runTests();
        int          pendingAcq;
        int          frameAcq;
        int          expTotal;
        int          wordIdx;
        int          limit;
        int          errStart;
        int          k;
        logic [63:0] word;
        pendingAcq = DEFAULT_ACQ;
        expTotal   = 0;
        wordIdx    = 0;
        limit      = acqWords.size() * PIXEL_NUM * SAMPLES_PER_PIXEL * 8 + testAcq.size() * 200;
        fork
            watchdog(limit);
        join_none
        for (int t = 0; t < testAcq.size(); t++) begin
            errStart = errors;
            // lands in CLEAR, so this frame picks it up
            if (testAcq[t] != 0) begin
                writeConfig(acqT'(testAcq[t]));
                pendingAcq = testAcq[t];
            end
            frameAcq = pendingAcq;
            expTotal += frameAcq * PIXEL_NUM * SAMPLES_PER_PIXEL;
            for (int a = 0; a < frameAcq; a++) begin
                word = acqWords[wordIdx];
                wordIdx++;
                for (int s = 0; s < PIXEL_NUM * SAMPLES_PER_PIXEL; s++) begin
                    k = a * PIXEL_NUM * SAMPLES_PER_PIXEL + s;
                    // mid-frame write, only the next frame sees it
                    if ((testCfgVal[t] != 0) && (k == testCfgIdx[t])) begin
                        writeConfig(acqT'(testCfgVal[t]));
                        pendingAcq = testCfgVal[t];
                    end
                    sendSample(binT'(word[63 - 4 * s -: 4]));
                end
            end
            // source keeps asking through the report, no ack may come back
            sampleReq <= 1'b1;
            receiveReport(t);
            while (frameCount == frameCntT'(t)) @(posedge clk);
            // back in CLEAR, withdraw the pending request
            sampleReq <= 1'b0;
            checkFrame(frameCount, frameCntT'(t + 1), "frame count");
            if ((ackAtReport != expTotal) || (ackTotal != expTotal)) begin
                errors++;
                $display("[ERROR] %0t sample acks: %0d before report, %0d after, expected %0d",
                    $time, ackAtReport, ackTotal, expTotal);
            end
            testsRun++;
            if (errors != errStart) begin
                testsFailed++;
            end
            $display("test %0d, %0d acquisitions: %s", t + 1, frameAcq,
                (errors == errStart) ? "ok" : "FAILED");
        end
    endtask

    initial begin
        combin_res = 1'b0;
        sampleReq  = 1'b0;
        sampleBin  = '0;
        peakAck    = 1'b0;
        cfgWrite   = 1'b0;
        cfgAcq     = acqT'(DEFAULT_ACQ);
        repeat (3) @(posedge clk);
        combin_res <= 1'b1;
        if (loadVectors()) begin
            runTests();
        end else begin
            errors++;
            $display("could not read any test from testbench/hisBuilder_vectors.txt");
        end
        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* testbench/hisBuilder_vectors.txt */
# T test acq cfgIdx cfgVal (decimal); acq 0 keeps the pending value, cfgVal 0 means no write
# S one acquisition, 16 hex bins pixel-major; E expected bin and count (hex) per pixel
T 1 1 0 0
S 33537279AAAA0FF1
E 3 3 7 2 A 4 F 2
T 2 3 0 0
S 12145555CDEF9999
S 22615500CCDD9999
S 18885000DCEE9999
E 1 4 5 7 D 4 9 C
T 3 1 0 0
S 4664B33B0123EDDE
E 6 2 3 2 0 1 D 2
T 4 0 0 0
S 1114FFFF277256EE
E 1 3 F 4 7 2 E 2
T 5 2 5 3
S 888801234444ABAB
S 777733335454BABA
E 8 4 3 5 4 6 B 4
T 6 0 0 0
S 222366661F1F0000
S 33326677F1F10001
S 2333777711111111
E 3 7 6 6 1 8 0 7

/* hisBuilder.f */
design/hisPkg.sv
design/frameConfig.sv
design/histSeqCtrl.sv
design/histRam.sv
design/peakTracker.sv
design/hisBuilder.sv
testbench/hisBuilder_chk.sv
testbench/hisBuilderTb.sv

/* run.sh */
#!/bin/sh
# compile and run the histogram builder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module hisBuilderTb -f hisBuilder.f -o hisBuilderSim

./obj_dir/hisBuilderSim > sim.log 2>&1 || true
cat sim.log

# verdict comes from the log
grep -q "^Testbench passed$" sim.log
